/* idct_cfg.svh */
////////////////////////////////////////
// Sizes and scaling of the 8x8 IDCT
// Changing a width here does not resize the coefficient table
////////////////////////////////////////
`ifndef IDCT_CFG_SVH
`define IDCT_CFG_SVH

// Block edge, elements per row and per column
`define IDCT_N 8

// Stream and store word, multiplier operand, accumulator
`define IDCT_DATA_W 32
`define IDCT_OPND_W 24
`define IDCT_SUM_W 35

// Right shifts applied to a product, to an 8-tap sum and to Temp
`define IDCT_PROD_SHIFT 16
`define IDCT_SUM_SHIFT 3
`define IDCT_TEMP_SHIFT 8

`endif

/* idctCtrlPkg.sv */
////////////////////////////////////////
// Control types of the IDCT engine
////////////////////////////////////////
`default_nettype none

package idctCtrlPkg;

   // Engine walk: load, row pass, column pass, stream out
   typedef enum logic [2:0]
   {
      Idle, Load, RowPass, RowFlush, ColPass, ColFlush, Emit
   } engineState;

   // Operand source and destination store of the running pass
   typedef enum logic {RowSel, ColSel} passSel;

endpackage

`default_nettype wire

/* idctDataPkg.sv */
////////////////////////////////////////
// Datapath types and cosine table
// Table entries are 16-bit two's complement
////////////////////////////////////////
`default_nettype none

`include "idct_cfg.svh"

package idctDataPkg;

   typedef logic signed [`IDCT_DATA_W-1:0] dataWord;
   typedef logic signed [`IDCT_OPND_W-1:0] operand;
   typedef logic signed [`IDCT_SUM_W-1:0] accWord;

   // Row-major element number, row in the upper half
   typedef logic [5:0] elemIndex;

   // C[r][c] at index r*8+c, negative values stored as raw 16-bit words
   localparam logic [15:0] CosTable [`IDCT_N*`IDCT_N] = '{
      16'd23170, 16'd32138, 16'd30274, 16'd27246,
      16'd23170, 16'd18205, 16'd12540, 16'd6393,
      16'd23170, 16'd27246, 16'd12540, 16'd59143,
      16'd42366, 16'd33398, 16'd35262, 16'd47331,
      16'd23170, 16'd18205, 16'd52996, 16'd33398,
      16'd42366, 16'd6393, 16'd30274, 16'd27246,
      16'd23170, 16'd6393, 16'd35262, 16'd47331,
      16'd23170, 16'd27246, 16'd52996, 16'd33398,
      16'd23170, 16'd59143, 16'd35262, 16'd18205,
      16'd23170, 16'd38290, 16'd52996, 16'd32138,
      16'd23170, 16'd47331, 16'd52996, 16'd32138,
      16'd42366, 16'd59143, 16'd30274, 16'd38290,
      16'd23170, 16'd38290, 16'd12540, 16'd6393,
      16'd42366, 16'd32138, 16'd35262, 16'd18205,
      16'd23170, 16'd33398, 16'd30274, 16'd38290,
      16'd23170, 16'd47331, 16'd12540, 16'd59143
   };

   // Coefficient C[r][c] sign-extended to operand width
   function automatic operand cosCoef(input logic [2:0] r, input logic [2:0] c);
      logic signed [15:0] raw;
      raw = $signed(CosTable[{r, c}]);
      return operand'(raw);
   endfunction

endpackage

`default_nettype wire

/* idctSequencer.sv */
////////////////////////////////////////
// Block FSM: load, two MAC passes, emit
// start is taken only in Idle and only after outValid has dropped
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module idctSequencer import idctCtrlPkg::*;
(
   input  wire logic clk,
   input  wire logic racc,
   input  wire logic start,
   input  wire logic lastElem,
   input  wire logic macResultValid,
   output logic      countClear,
   output logic      countStep,
   output logic      loadEn,
   output logic      emitEn,
   output logic      macRun,
   output passSel    pass,
   output logic      reading,
   output logic      outValid,
   output logic      done
);

   engineState state;
   engineState nextState;

   // Clear and step together moves the counter one whole element
   always_comb
   begin
      nextState  = state;
      countClear = 1'b0;
      countStep  = 1'b0;
      loadEn     = 1'b0;
      emitEn     = 1'b0;
      macRun     = 1'b0;
      case (state)
         Idle:
         begin
            countClear = 1'b1;
            if (start && !outValid)
               nextState = Load;
         end
         Load:
         begin
            loadEn     = 1'b1;
            countClear = 1'b1;
            countStep  = !lastElem;
            if (lastElem)
               nextState = RowPass;
         end
         RowPass, ColPass:
         begin
            // Count wraps to zero after the last tap
            macRun    = 1'b1;
            countStep = 1'b1;
            if (lastElem)
               nextState = (state == RowPass) ? RowFlush : ColFlush;
         end
         RowFlush:
            if (macResultValid)
               nextState = ColPass;
         ColFlush:
            if (macResultValid)
               nextState = Emit;
         Emit:
         begin
            emitEn     = 1'b1;
            countClear = 1'b1;
            countStep  = !lastElem;
            if (lastElem)
               nextState = Idle;
         end
         default:
            nextState = Idle;
      endcase
   end

   assign pass = (state == ColPass || state == ColFlush) ? ColSel : RowSel;

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         state    <= Idle;
         reading  <= 1'b0;
         outValid <= 1'b0;
         done     <= 1'b0;
      end
      else
      begin
         state    <= nextState;
         reading  <= (nextState == Load);
         // dout is registered in the store, so valid trails Emit by one cycle
         outValid <= (state == Emit);
         done     <= outValid && (state != Emit);
      end
   end

endmodule

`default_nettype wire

/* idctIndexCounter.sv */
////////////////////////////////////////
// Element and tap counter of the engine
// Write-back indices trail by two cycles
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "idct_cfg.svh"

module idctIndexCounter import idctDataPkg::*;
(
   input  wire logic  clk,
   input  wire logic  racc,
   input  wire logic  countClear,
   input  wire logic  countStep,
   output logic [2:0] rowIdx,
   output logic [2:0] colIdx,
   output logic [2:0] tapIdx,
   output logic [2:0] wbRow,
   output logic [2:0] wbCol,
   output elemIndex   elemIdx,
   output logic       lastElem
);

   localparam int CountW = $clog2(`IDCT_N * `IDCT_N * `IDCT_N);

   logic [CountW-1:0] count;
   logic [5:0]        rowCol1;
   logic [5:0]        rowCol2;

   // Layout is {row, col, tap}, tap fastest
   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
         count <= '0;
      else if (countClear && countStep)
         count <= {count[CountW-1:3] + 6'd1, 3'd7};
      else if (countClear)
         count <= '0;
      else if (countStep)
         count <= count + 1'b1;
   end

   // Matches product and accumulator stages of the MAC
   always_ff @(posedge clk)
   begin
      rowCol1 <= {rowIdx, colIdx};
      rowCol2 <= rowCol1;
   end

   assign rowIdx   = count[8:6];
   assign colIdx   = count[5:3];
   assign tapIdx   = count[2:0];
   assign elemIdx  = count[8:3];
   assign lastElem = &count;
   assign wbRow    = rowCol2[5:3];
   assign wbCol    = rowCol2[2:0];

endmodule

`default_nettype wire

/* idctBlockStore.sv */
////////////////////////////////////////
// In, Temp and Out block stores
// Arrays hold no reset, only dout does
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "idct_cfg.svh"

module idctBlockStore import idctDataPkg::*, idctCtrlPkg::*;
(
   input  wire logic       clk,
   input  wire logic       racc,
   input  wire logic       loadEn,
   input  wire logic       emitEn,
   input  wire passSel     pass,
   input  wire dataWord    din,
   input  wire elemIndex   elemIdx,
   input  wire logic [2:0] rowIdx,
   input  wire logic [2:0] colIdx,
   input  wire logic [2:0] tapIdx,
   input  wire logic [2:0] wbRow,
   input  wire logic [2:0] wbCol,
   input  wire dataWord    macResult,
   input  wire logic       macResultValid,
   output operand          opA,
   output dataWord         dout
);

   dataWord inBlk   [`IDCT_N][`IDCT_N];
   dataWord tempBlk [`IDCT_N][`IDCT_N];
   dataWord outBlk  [`IDCT_N][`IDCT_N];
   dataWord tempWord;

   // Row pass reads In along a row, column pass reads Temp down a column
   assign tempWord = tempBlk[tapIdx][colIdx] >>> `IDCT_TEMP_SHIFT;
   assign opA = (pass == RowSel) ? operand'(inBlk[rowIdx][tapIdx]) : operand'(tempWord);

   always_ff @(posedge clk)
   begin
      if (loadEn)
         inBlk[elemIdx[5:3]][elemIdx[2:0]] <= din;
      if (macResultValid)
      begin
         if (pass == RowSel)
            tempBlk[wbRow][wbCol] <= macResult;
         else
            outBlk[wbRow][wbCol] <= macResult;
      end
   end

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
         dout <= '0;
      else if (emitEn)
         dout <= outBlk[elemIdx[5:3]][elemIdx[2:0]];
   end

endmodule

`default_nettype wire

/* idctMac.sv */
////////////////////////////////////////
// Shared multiply-accumulate, two stages
// Expects taps 0..7 of one element in a row
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "idct_cfg.svh"

module idctMac import idctDataPkg::*, idctCtrlPkg::*;
(
   input  wire logic       clk,
   input  wire logic       racc,
   input  wire logic       macRun,
   input  wire operand     opA,
   input  wire passSel     pass,
   input  wire logic [2:0] rowIdx,
   input  wire logic [2:0] colIdx,
   input  wire logic [2:0] tapIdx,
   output dataWord         macResult,
   output logic            macResultValid
);

   operand                           coef;
   logic signed [2*`IDCT_OPND_W-1:0] fullProd;
   dataWord                          prodReg;
   logic [2:0]                       prodTap;
   logic                             prodValid;
   accWord                           accReg;

   // C[col][tap] for rows, C[row][tap] for columns
   assign coef     = (pass == RowSel) ? cosCoef(colIdx, tapIdx) : cosCoef(rowIdx, tapIdx);
   assign fullProd = opA * coef;

   always_ff @(posedge clk)
   begin
      prodReg <= dataWord'(fullProd >>> `IDCT_PROD_SHIFT);
      prodTap <= tapIdx;
      if (prodValid)
         accReg <= (prodTap == 3'd0) ? accWord'(prodReg) : accReg + accWord'(prodReg);
   end

   always_ff @(posedge clk or posedge racc)
   begin
      if (racc)
      begin
         prodValid      <= 1'b0;
         macResultValid <= 1'b0;
      end
      else
      begin
         prodValid      <= macRun;
         macResultValid <= prodValid && (prodTap == 3'd7);
      end
   end

   assign macResult = dataWord'(accReg >>> `IDCT_SUM_SHIFT);

endmodule

`default_nettype wire

/* idctTop.sv */
////////////////////////////////////////
// 8x8 inverse DCT, one shared multiplier
// No back-pressure on din or dout
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module idctTop import idctDataPkg::*, idctCtrlPkg::*;
(
   input  wire logic    clk,
   input  wire logic    racc,
   input  wire logic    start,
   input  wire dataWord din,
   output logic         reading,
   output logic         outValid,
   output logic         done,
   output dataWord      dout
);

   logic       countClear;
   logic       countStep;
   logic       lastElem;
   logic       loadEn;
   logic       emitEn;
   logic       macRun;
   passSel     pass;
   logic [2:0] rowIdx;
   logic [2:0] colIdx;
   logic [2:0] tapIdx;
   logic [2:0] wbRow;
   logic [2:0] wbCol;
   elemIndex   elemIdx;
   operand     opA;
   dataWord    macResult;
   logic       macResultValid;

   idctSequencer sequencer (
      .clk(clk), .racc(racc), .start(start), .lastElem(lastElem),
      .macResultValid(macResultValid), .countClear(countClear), .countStep(countStep),
      .loadEn(loadEn), .emitEn(emitEn), .macRun(macRun), .pass(pass),
      .reading(reading), .outValid(outValid), .done(done)
   );

   idctIndexCounter counter (
      .clk(clk), .racc(racc), .countClear(countClear), .countStep(countStep),
      .rowIdx(rowIdx), .colIdx(colIdx), .tapIdx(tapIdx), .wbRow(wbRow), .wbCol(wbCol),
      .elemIdx(elemIdx), .lastElem(lastElem)
   );

   idctBlockStore store (
      .clk(clk), .racc(racc), .loadEn(loadEn), .emitEn(emitEn), .pass(pass),
      .din(din), .elemIdx(elemIdx), .rowIdx(rowIdx), .colIdx(colIdx), .tapIdx(tapIdx),
      .wbRow(wbRow), .wbCol(wbCol), .macResult(macResult),
      .macResultValid(macResultValid), .opA(opA), .dout(dout)
   );

   idctMac mac (
      .clk(clk), .racc(racc), .macRun(macRun), .opA(opA), .pass(pass),
      .rowIdx(rowIdx), .colIdx(colIdx), .tapIdx(tapIdx),
      .macResult(macResult), .macResultValid(macResultValid)
   );

endmodule

`default_nettype wire

/* idctTb.sv */
////////////////////////////////////////
// Self-checking testbench of the 8x8 IDCT
// Source and sink never stall, as the engine requires
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

`include "idct_cfg.svh"

module idctTb import idctDataPkg::*;
();

   localparam int NumTests = 6;
   // 64 loads, two passes of 512 taps plus flush, 64 outputs, with slack
   localparam int BlockCycles = 1300;
   // Reset-abort and back-to-back entries each run one extra block
   localparam int TimeoutCycles = (NumTests + 2) * BlockCycles;

   typedef enum {Impulse, Constant, Ramp, Random, ResetAbort, BackToBack} blockKind;

   string testName [NumTests] = '{"impulse", "constant", "ramp", "random",
      "resetAbort", "backToBack"};
   blockKind testKind [NumTests] = '{Impulse, Constant, Ramp, Random, ResetAbort, BackToBack};
   int seedOff [NumTests] = '{0, 3, 5, 7, 11, 13};

   logic        clk = 1'b0;
   logic        racc;
   logic        start;
   dataWord     din;
   logic        reading;
   logic        outValid;
   logic        done;
   dataWord     dout;
   dataWord     stim [64];
   dataWord     expOut [64];
   int          cycleCount = 0;

   idctTop DUT (.clk(clk), .racc(racc), .start(start), .din(din), .reading(reading),
      .outValid(outValid), .done(done), .dout(dout));

   always #4 clk = ~clk;

   always @(posedge clk)
   begin
      cycleCount = cycleCount + 1;
      if (cycleCount > TimeoutCycles)
      begin
         $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
         $display("Verification failed");
         $fatal(1, "Timeout");
      end
   end

   task automatic checkValue(input string name, input string what, input dataWord expected,
      input dataWord actual);
      assert (actual === expected)
      else
      begin
         $display("ERROR %s %s: expected %0d actual %0d", name, what, expected, actual);
         $display("Verification failed");
         $fatal(1, "Wrong value");
      end
   endtask

   task automatic checkFlag(input string name, input logic ok, input string msg);
      assert (ok)
      else
      begin
         $display("%s: %s", name, msg);
         $display("Verification failed");
         $fatal(1, "Protocol check failed");
      end
   endtask

   // dout keeps the last word of a block, it is zero only after reset
   task automatic idleFor(input string name, input int cycles, input logic doutZero);
      repeat (cycles)
      begin
         @(negedge clk);
         checkFlag(name, !reading && !outValid && !done, "a handshake output is high while idle");
         if (doutZero)
            checkValue(name, "dout", '0, dout);
      end
   endtask

   // Exact signed product, scaled down and cut to a word
   function automatic dataWord scaledProd(input operand a, input operand b);
      logic signed [47:0] p;
      p = 48'(a) * 48'(b);
      return dataWord'(p >>> `IDCT_PROD_SHIFT);
   endfunction

   // Row pass into tmp, then column pass into expOut
   task automatic computeModel();
      dataWord tmp [8][8];
      accWord  acc;
      dataWord t;
      for (int j = 0; j < 8; j++)
         for (int i = 0; i < 8; i++)
         begin
            acc = '0;
            for (int k = 0; k < 8; k++)
               acc = acc + accWord'(scaledProd(operand'(stim[j*8+k]), cosCoef(3'(i), 3'(k))));
            tmp[j][i] = dataWord'(acc >>> `IDCT_SUM_SHIFT);
         end
      for (int j = 0; j < 8; j++)
         for (int i = 0; i < 8; i++)
         begin
            acc = '0;
            for (int k = 0; k < 8; k++)
            begin
               t   = tmp[k][i] >>> `IDCT_TEMP_SHIFT;
               acc = acc + accWord'(scaledProd(operand'(t), cosCoef(3'(j), 3'(k))));
            end
            expOut[j*8+i] = dataWord'(acc >>> `IDCT_SUM_SHIFT);
         end
   endtask

   task automatic fillBlock(input blockKind kind, input int off);
      int v;
      for (int e = 0; e < 64; e++)
      begin
         case (kind)
            Impulse:  v = (e == 0) ? (1 << 20) + off : 0;
            Constant: v = 200000 + off * 1000;
            Ramp:     v = (e - 32) * 8192 + off;
            // Draw within +-2047, scaled so the column pass sees nonzero operands
            default:  v = (int'(($urandom + off) % 4095) - 2047) * 1024;
         endcase
         stim[e] = dataWord'(v);
         // Upper byte is junk, only the low 24 bits reach the datapath
         if (kind == Random)
            stim[e][31:24] = 8'($urandom);
      end
   endtask

   // Loads stim, then resets after abortAt cycles or checks all 64 outputs
   task automatic runBlock(input string name, input logic holdStart, input int abortAt);
      int idx;
      int waitCycles;
      computeModel();
      start = 1'b1;
      while (!reading)
         @(negedge clk);
      start = holdStart;
      for (int e = 0; e < 64; e++)
      begin
         checkFlag(name, reading, "reading dropped before 64 words were taken");
         din = stim[e];
         @(negedge clk);
      end
      checkFlag(name, !reading, "reading stayed high after 64 words");
      din = 32'h5a5a5a5a;
      if (abortAt > 0)
      begin
         repeat (abortAt) @(negedge clk);
         racc = 1'b1;
         idleFor(name, 3, 1'b1);
         racc = 1'b0;
         return;
      end
      waitCycles = 0;
      while (!outValid)
      begin
         checkFlag(name, !reading && !done, "reading or done rose while the engine was busy");
         // Short start pulses while busy
         start = holdStart || (waitCycles % 250 == 100);
         waitCycles++;
         @(negedge clk);
      end
      start = holdStart;
      idx = 0;
      while (outValid)
      begin
         checkFlag(name, idx < 64 && !reading && !done, "outValid ran past 64 words or overlapped");
         checkValue(name, $sformatf("Out[%0d][%0d]", idx / 8, idx % 8), expOut[idx], dout);
         idx++;
         @(negedge clk);
      end
      checkFlag(name, idx == 64, "fewer than 64 outValid cycles");
      checkFlag(name, done, "done did not follow the last outValid");
      @(negedge clk);
      checkFlag(name, !done, "done stayed high for more than one cycle");
   endtask

   initial
   begin
      void'($urandom(32'h695acaf8));
      racc  = 1'b1;
      start = 1'b0;
      din   = '0;
      repeat (3) @(negedge clk);
      racc = 1'b0;
      idleFor("reset", 10, 1'b1);
      for (int t = 0; t < NumTests; t++)
      begin
         $display("Running %s", testName[t]);
         case (testKind[t])
            ResetAbort:
            begin
               fillBlock(Random, seedOff[t]);
               runBlock(testName[t], 1'b0, 300);
               idleFor(testName[t], 5, 1'b1);
               fillBlock(Random, seedOff[t] + 1);
               runBlock(testName[t], 1'b0, 0);
            end
            BackToBack:
            begin
               fillBlock(Random, seedOff[t]);
               runBlock(testName[t], 1'b1, 0);
               checkFlag(testName[t], reading, "start held through done did not restart");
               fillBlock(Ramp, seedOff[t]);
               runBlock(testName[t], 1'b0, 0);
            end
            default:
            begin
               fillBlock(testKind[t], seedOff[t]);
               runBlock(testName[t], 1'b0, 0);
            end
         endcase
         idleFor(testName[t], 4, 1'b0);
      end
      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
+incdir+.
idctCtrlPkg.sv
idctDataPkg.sv
idctSequencer.sv
idctIndexCounter.sv
idctBlockStore.sv
idctMac.sv
idctTop.sv
idctTb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module idctTb -o idctSim &&
./obj_dir/idctSim | tee /dev/stderr | grep -q "Verification passed" &&
echo "RUN OK" && exit 0 || { echo "RUN FAILED"; exit 1; }
